//--- rv_front_defines.svh
`ifndef RV_FRONT_DEFINES_SVH
`define RV_FRONT_DEFINES_SVH

// datapath width of the core
`define RV_XLEN 32

// RV32E has sixteen architectural registers
`define RV_REG_AW 4
`define RV_NREGS 16

`endif

//--- rv_decode_pkg.sv
package rv_decode_pkg;

	////////////////////
	// instruction classes
	////////////////////

	// taken from opcode bits 6..2, cls_none for anything outside the subset
	typedef enum logic [3:0] {
		cls_none,
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_beq,
		cls_lw,
		cls_sw,
		cls_addi,
		cls_add,
		cls_csr
	} inst_class_e;

	////////////////////
	// immediate formats
	////////////////////

	typedef enum logic [2:0] {
		fmt_r,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j,
		fmt_none // no immediate, imm reads zero
	} imm_fmt_e;

endpackage

//--- rv_pipe_pkg.sv
`include "rv_front_defines.svh"

package rv_pipe_pkg;

	////////////////////
	// decode -> execute
	////////////////////

	// contents of the one-entry stage register
	typedef struct packed {
		rv_decode_pkg::inst_class_e cls;
		logic [2:0]                 funct3;
		logic                       funct7_5;
		logic [`RV_REG_AW-1:0]      rd;
		logic [`RV_XLEN-1:0]        imm;
		logic                       reg_wen;
		logic                       fencei;
		logic                       ecall;
		logic                       mret;
		logic [`RV_XLEN-1:0]        pc;
		logic [`RV_XLEN-1:0]        dnpc; // predicted next pc
		logic [`RV_XLEN-1:0]        src1; // already forwarded
		logic [`RV_XLEN-1:0]        src2;
	} decoded_t;

endpackage

//--- rv_bypass_if.sv
`timescale 1ns/1ps

`include "rv_front_defines.svh"

// in-flight write of one later stage, seen by decode
interface rv_bypass_if;

	logic [`RV_REG_AW-1:0] rd;
	logic                  reg_wen;
	logic                  load; // result not known until memory returns
	logic                  done; // stage has finished, regfile will hold it
	logic [`RV_XLEN-1:0]   val;

	modport producer (
		output rd,
		output reg_wen,
		output load,
		output done,
		output val
	);

	modport consumer (
		input rd,
		input reg_wen,
		input load,
		input done,
		input val
	);

endinterface

//--- rv_regfile.sv
`timescale 1ns/1ps

`include "rv_front_defines.svh"

module rv_regfile (
	input  logic                  clock,
	input  logic                  rst,

	input  logic                  wen,
	input  logic [`RV_REG_AW-1:0] waddr,
	input  logic [`RV_XLEN-1:0]   wdata,

	input  logic [`RV_REG_AW-1:0] raddr1,
	input  logic [`RV_REG_AW-1:0] raddr2,
	output logic [`RV_XLEN-1:0]   rdata1,
	output logic [`RV_XLEN-1:0]   rdata2
);

	logic [`RV_XLEN-1:0] regs [`RV_NREGS];

	////////////////////
	// write port
	////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin // x0 stays zero
			regs[waddr] <= wdata;
		end
	end

	////////////////////
	// read ports
	////////////////////

	// no bypass from the write port, a same-cycle read sees the old value
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	// x0 is never written, so both ports must see zero there
	a_x0_zero: assert property (@(posedge clock) disable iff (rst)
		((raddr1 != '0) || (rdata1 == '0)) && ((raddr2 != '0) || (rdata2 == '0)));

endmodule

//--- rv_imm_gen.sv
`timescale 1ns/1ps

`include "rv_front_defines.svh"

module rv_imm_gen (
	input  logic [`RV_XLEN-1:0]        inst,
	output rv_decode_pkg::inst_class_e cls,
	output logic [`RV_XLEN-1:0]        imm,
	output logic                       reg_wen
);

	rv_decode_pkg::imm_fmt_e fmt;

	always_comb begin
		cls = rv_decode_pkg::cls_none;
		fmt = rv_decode_pkg::fmt_none;
		case (inst[6:2])
			5'b01101: begin cls = rv_decode_pkg::cls_lui;   fmt = rv_decode_pkg::fmt_u; end
			5'b00101: begin cls = rv_decode_pkg::cls_auipc; fmt = rv_decode_pkg::fmt_u; end
			5'b11011: begin cls = rv_decode_pkg::cls_jal;   fmt = rv_decode_pkg::fmt_j; end
			5'b11001: begin cls = rv_decode_pkg::cls_jalr;  fmt = rv_decode_pkg::fmt_i; end
			5'b11000: begin cls = rv_decode_pkg::cls_beq;   fmt = rv_decode_pkg::fmt_b; end
			5'b00000: begin cls = rv_decode_pkg::cls_lw;    fmt = rv_decode_pkg::fmt_i; end
			5'b01000: begin cls = rv_decode_pkg::cls_sw;    fmt = rv_decode_pkg::fmt_s; end
			5'b00100: begin cls = rv_decode_pkg::cls_addi;  fmt = rv_decode_pkg::fmt_i; end
			5'b01100: begin cls = rv_decode_pkg::cls_add;   fmt = rv_decode_pkg::fmt_r; end
			5'b11100: begin cls = rv_decode_pkg::cls_csr;   fmt = rv_decode_pkg::fmt_i; end
			default: ; // fence.i and unknown opcodes
		endcase
	end

	always_comb begin
		case (fmt)
			rv_decode_pkg::fmt_i: imm = {{20{inst[31]}}, inst[31:20]};
			rv_decode_pkg::fmt_u: imm = {inst[31:12], 12'b0};
			rv_decode_pkg::fmt_s: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			rv_decode_pkg::fmt_b: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			rv_decode_pkg::fmt_j: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			default:              imm = '0;
		endcase
	end

	// ecall, mret and other funct3 == 0 system words write nothing
	assign reg_wen = (fmt == rv_decode_pkg::fmt_r) || (fmt == rv_decode_pkg::fmt_u) ||
		(fmt == rv_decode_pkg::fmt_j) ||
		((fmt == rv_decode_pkg::fmt_i) &&
		!((cls == rv_decode_pkg::cls_csr) && (inst[14:12] == 3'b000)));

endmodule

//--- rv_hazard.sv
`timescale 1ns/1ps

`include "rv_front_defines.svh"

module rv_hazard (
	input  logic                  need_rs1,
	input  logic                  need_rs2,
	input  logic [`RV_REG_AW-1:0] rs1,
	input  logic [`RV_REG_AW-1:0] rs2,
	input  logic [`RV_XLEN-1:0]   rf_src1,
	input  logic [`RV_XLEN-1:0]   rf_src2,

	rv_bypass_if.consumer         exu_bp,
	rv_bypass_if.consumer         lsu_bp,

	output logic [`RV_XLEN-1:0]   src1,
	output logic [`RV_XLEN-1:0]   src2,
	output logic                  stall
);

	logic rs1_exu_hit;
	logic rs2_exu_hit;
	logic rs1_lsu_hit;
	logic rs2_lsu_hit;
	logic load_busy;

	// a busy stage that will write the register we are about to read
	function automatic logic conflict(
		input logic                  done,
		input logic                  need,
		input logic [`RV_REG_AW-1:0] rd,
		input logic                  wen,
		input logic [`RV_REG_AW-1:0] rs
	);
		return !done && need && (rd == rs) && wen && (rd != '0);
	endfunction

	assign rs1_exu_hit = conflict(exu_bp.done, need_rs1, exu_bp.rd, exu_bp.reg_wen, rs1);
	assign rs2_exu_hit = conflict(exu_bp.done, need_rs2, exu_bp.rd, exu_bp.reg_wen, rs2);
	assign rs1_lsu_hit = conflict(lsu_bp.done, need_rs1, lsu_bp.rd, lsu_bp.reg_wen, rs1);
	assign rs2_lsu_hit = conflict(lsu_bp.done, need_rs2, lsu_bp.rd, lsu_bp.reg_wen, rs2);

	////////////////////
	// forwarding
	////////////////////

	// execute holds the younger value, so it wins over memory
	assign src1 = rs1_exu_hit ? exu_bp.val :
		rs1_lsu_hit ? lsu_bp.val : rf_src1;
	assign src2 = rs2_exu_hit ? exu_bp.val :
		rs2_lsu_hit ? lsu_bp.val : rf_src2;

	// load data is not there yet, wait for done
	assign stall = (exu_bp.load && (rs1_exu_hit || rs2_exu_hit)) ||
		(lsu_bp.load && (rs1_lsu_hit || rs2_lsu_hit));

	assign load_busy = (exu_bp.load && !exu_bp.done) || (lsu_bp.load && !lsu_bp.done);

	a_stall_load: assert final (!stall || load_busy);

endmodule

//--- rv_idu.sv
`timescale 1ns/1ps

`include "rv_front_defines.svh"

module rv_idu (
	input  logic                   clock,
	input  logic                   rst,

	input  logic [`RV_XLEN-1:0]    inst,
	input  logic [`RV_XLEN-1:0]    pc,
	input  logic [`RV_XLEN-1:0]    dnpc,

	// register file read
	output logic [`RV_REG_AW-1:0]  rs1,
	output logic [`RV_REG_AW-1:0]  rs2,
	input  logic [`RV_XLEN-1:0]    rf_src1,
	input  logic [`RV_XLEN-1:0]    rf_src2,

	rv_bypass_if.consumer          exu_bp,
	rv_bypass_if.consumer          lsu_bp,

	input  logic                   jump_wrong,

	input  logic                   idu_valid,
	output logic                   idu_ready,
	output logic                   exu_valid,
	input  logic                   exu_ready,
	output rv_pipe_pkg::decoded_t  dec
);

	typedef enum logic {
		stage_empty,
		stage_full
	} stage_e;

	stage_e                     state;
	stage_e                     state_next;
	rv_decode_pkg::inst_class_e cls;
	logic [`RV_XLEN-1:0]        imm;
	logic                       reg_wen;
	logic                       need_rs1;
	logic                       need_rs2;
	logic [`RV_XLEN-1:0]        src1;
	logic [`RV_XLEN-1:0]        src2;
	logic                       stall;
	logic                       accept;
	rv_pipe_pkg::decoded_t      dec_next;

	////////////////////
	// field decode
	////////////////////

	assign rs1 = inst[15 +: `RV_REG_AW]; // RV32E, top bit of each field ignored
	assign rs2 = inst[20 +: `RV_REG_AW];

	rv_imm_gen rv_imm_gen_i (
		.inst    (inst),
		.cls     (cls),
		.imm     (imm),
		.reg_wen (reg_wen)
	);

	assign need_rs2 = cls inside {rv_decode_pkg::cls_beq, rv_decode_pkg::cls_sw,
		rv_decode_pkg::cls_add};
	assign need_rs1 = need_rs2 || (cls inside {rv_decode_pkg::cls_jalr, rv_decode_pkg::cls_lw,
		rv_decode_pkg::cls_addi, rv_decode_pkg::cls_csr});

	rv_hazard rv_hazard_i (
		.need_rs1 (need_rs1),
		.need_rs2 (need_rs2),
		.rs1      (rs1),
		.rs2      (rs2),
		.rf_src1  (rf_src1),
		.rf_src2  (rf_src2),
		.exu_bp   (exu_bp),
		.lsu_bp   (lsu_bp),
		.src1     (src1),
		.src2     (src2),
		.stall    (stall)
	);

	always_comb begin
		dec_next.cls      = cls;
		dec_next.funct3   = inst[14:12];
		dec_next.funct7_5 = inst[30];
		dec_next.rd       = inst[7 +: `RV_REG_AW];
		dec_next.imm      = imm;
		dec_next.reg_wen  = reg_wen;
		dec_next.fencei   = (inst[6:2] == 5'b00011);
		dec_next.ecall    = (inst == 32'h0000_0073);
		dec_next.mret     = (inst == 32'h3020_0073);
		dec_next.pc       = pc;
		dec_next.dnpc     = dnpc;
		dec_next.src1     = src1;
		dec_next.src2     = src2;
	end

	////////////////////
	// stage register
	////////////////////

	assign idu_ready = (state == stage_empty) && !stall;
	assign exu_valid = (state == stage_full);
	assign accept    = idu_valid && idu_ready;

	always_comb begin
		state_next = state;
		if (jump_wrong)
			state_next = stage_empty; // wrong path, drop whatever is held
		else if (state == stage_empty && accept)
			state_next = stage_full;
		else if (state == stage_full && exu_ready)
			state_next = stage_empty;
	end

	always_ff @(posedge clock) begin
		if (rst)
			state <= stage_empty;
		else
			state <= state_next;
	end

	always_ff @(posedge clock) begin
		if (accept)
			dec <= dec_next;
	end

	// execute may sample any time until it takes the item
	a_dec_hold: assert property (@(posedge clock) disable iff (rst)
		(exu_valid && !exu_ready) |=> $stable(dec));

endmodule

//--- rv_front_top.sv
`timescale 1ns/1ps

`include "rv_front_defines.svh"

module rv_front_top (
	input  logic                  clock,
	input  logic                  rst,

	input  logic [`RV_XLEN-1:0]   inst,
	input  logic [`RV_XLEN-1:0]   pc,
	input  logic [`RV_XLEN-1:0]   dnpc,
	input  logic                  idu_valid,
	output logic                  idu_ready,

	// writeback into the register file
	input  logic                  wb_en,
	input  logic [`RV_REG_AW-1:0] wb_rd,
	input  logic [`RV_XLEN-1:0]   wb_data,

	input  logic [`RV_REG_AW-1:0] exu_rd,
	input  logic                  exu_reg_wen,
	input  logic                  exu_load,
	input  logic [`RV_XLEN-1:0]   exu_val,
	input  logic [`RV_REG_AW-1:0] lsu_rd,
	input  logic                  lsu_reg_wen,
	input  logic                  lsu_load,
	input  logic                  lsu_ready,
	input  logic [`RV_XLEN-1:0]   lsu_val,

	input  logic                  jump_wrong,

	output logic                  exu_valid,
	input  logic                  exu_ready, // also tells decode that execute is done
	output logic [3:0]            dec_cls,
	output logic [2:0]            dec_funct3,
	output logic                  dec_funct7_5,
	output logic [`RV_REG_AW-1:0] dec_rd,
	output logic [`RV_XLEN-1:0]   dec_imm,
	output logic                  dec_reg_wen,
	output logic                  dec_fencei,
	output logic                  dec_ecall,
	output logic                  dec_mret,
	output logic [`RV_XLEN-1:0]   dec_pc,
	output logic [`RV_XLEN-1:0]   dec_dnpc,
	output logic [`RV_XLEN-1:0]   dec_src1,
	output logic [`RV_XLEN-1:0]   dec_src2
);

	logic [`RV_REG_AW-1:0] rs1;
	logic [`RV_REG_AW-1:0] rs2;
	logic [`RV_XLEN-1:0]   rf_src1;
	logic [`RV_XLEN-1:0]   rf_src2;
	rv_pipe_pkg::decoded_t dec;

	rv_bypass_if exu_bp ();
	rv_bypass_if lsu_bp ();

	assign exu_bp.rd      = exu_rd;
	assign exu_bp.reg_wen = exu_reg_wen;
	assign exu_bp.load    = exu_load;
	assign exu_bp.done    = exu_ready;
	assign exu_bp.val     = exu_val;

	assign lsu_bp.rd      = lsu_rd;
	assign lsu_bp.reg_wen = lsu_reg_wen;
	assign lsu_bp.load    = lsu_load;
	assign lsu_bp.done    = lsu_ready;
	assign lsu_bp.val     = lsu_val;

	rv_regfile rv_regfile_i (
		.clock  (clock),
		.rst    (rst),
		.wen    (wb_en),
		.waddr  (wb_rd),
		.wdata  (wb_data),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (rf_src1),
		.rdata2 (rf_src2)
	);

	rv_idu rv_idu_i (
		.clock      (clock),
		.rst        (rst),
		.inst       (inst),
		.pc         (pc),
		.dnpc       (dnpc),
		.rs1        (rs1),
		.rs2        (rs2),
		.rf_src1    (rf_src1),
		.rf_src2    (rf_src2),
		.exu_bp     (exu_bp),
		.lsu_bp     (lsu_bp),
		.jump_wrong (jump_wrong),
		.idu_valid  (idu_valid),
		.idu_ready  (idu_ready),
		.exu_valid  (exu_valid),
		.exu_ready  (exu_ready),
		.dec        (dec)
	);

	assign dec_cls      = dec.cls;
	assign dec_funct3   = dec.funct3;
	assign dec_funct7_5 = dec.funct7_5;
	assign dec_rd       = dec.rd;
	assign dec_imm      = dec.imm;
	assign dec_reg_wen  = dec.reg_wen;
	assign dec_fencei   = dec.fencei;
	assign dec_ecall    = dec.ecall;
	assign dec_mret     = dec.mret;
	assign dec_pc       = dec.pc;
	assign dec_dnpc     = dec.dnpc;
	assign dec_src1     = dec.src1;
	assign dec_src2     = dec.src2;

endmodule

//--- tb_rv_front.sv
`timescale 1ns/1ps

module tb_rv_front;

	// six tests of at most ~300 cycles each, plus reset
	localparam int max_cycles = 6 * 300 + 200;

	logic        clock = 1'b0;
	logic        rst;
	logic [31:0] inst;
	logic [31:0] pc;
	logic [31:0] dnpc;
	logic        idu_valid;
	logic        idu_ready;
	logic        wb_en;
	logic [3:0]  wb_rd;
	logic [31:0] wb_data;
	logic [3:0]  exu_rd;
	logic        exu_reg_wen;
	logic        exu_load;
	logic [31:0] exu_val;
	logic [3:0]  lsu_rd;
	logic        lsu_reg_wen;
	logic        lsu_load;
	logic        lsu_ready;
	logic [31:0] lsu_val;
	logic        jump_wrong;
	logic        exu_valid;
	logic        exu_ready;
	logic [3:0]  dec_cls;
	logic [2:0]  dec_funct3;
	logic        dec_funct7_5;
	logic [3:0]  dec_rd;
	logic [31:0] dec_imm;
	logic        dec_reg_wen;
	logic        dec_fencei;
	logic        dec_ecall;
	logic        dec_mret;
	logic [31:0] dec_pc;
	logic [31:0] dec_dnpc;
	logic [31:0] dec_src1;
	logic [31:0] dec_src2;

	logic [31:0] model [16]; // expected register file contents
	logic [31:0] lfsr = 32'h49e1ab96;
	logic [31:0] exp_pc;
	logic [31:0] exp_dnpc;
	string       test_name;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;

	rv_front_top rv_front_top_i (.*);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles > max_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", max_cycles);
			$display("%0d checks, %0d errors", checks, errors + 1);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // one step per bit
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// {format, opcode bits 6..2} per class, in enum order
	// formats 0 R, 1 I, 2 S, 3 B, 4 U, 5 J
	function automatic logic [7:0] class_code(input int c);
		case (c)
			1:       return {3'd4, 5'b01101}; // lui
			2:       return {3'd4, 5'b00101}; // auipc
			3:       return {3'd5, 5'b11011}; // jal
			4:       return {3'd1, 5'b11001}; // jalr
			5:       return {3'd3, 5'b11000}; // beq
			6:       return {3'd1, 5'b00000}; // lw
			7:       return {3'd2, 5'b01000}; // sw
			8:       return {3'd1, 5'b00100}; // addi
			9:       return {3'd0, 5'b01100}; // add
			default: return {3'd1, 5'b11100}; // csr
		endcase
	endfunction

	function automatic logic [31:0] expect_imm(input logic [2:0] fmt, input logic [31:0] r);
		case (fmt)
			3'd1, 3'd2: return {{20{r[11]}}, r[11:0]};
			3'd3:       return {{19{r[12]}}, r[12:1], 1'b0};
			3'd4:       return {r[31:12], 12'b0};
			3'd5:       return {{11{r[20]}}, r[20:1], 1'b0};
			default:    return 32'b0;
		endcase
	endfunction

	// standard RV32 field layout, top bit of each register field left at zero
	function automatic logic [31:0] encode(input logic [2:0] fmt, input logic [4:0] opc,
		input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2,
		input logic [2:0] f3, input logic [6:0] f7, input logic [31:0] e);
		logic [31:0] w;
		w = {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, opc, 2'b11};
		case (fmt)
			3'd1:    w[31:20] = e[11:0];
			3'd2:    w = {e[11:5], 1'b0, rs2, 1'b0, rs1, f3, e[4:0], opc, 2'b11};
			3'd3:    w = {e[12], e[10:5], 1'b0, rs2, 1'b0, rs1, f3, e[4:1], e[11], opc, 2'b11};
			3'd4:    w[31:12] = e[31:12];
			3'd5:    w[31:12] = {e[20], e[10:1], e[11], e[19:12]};
			default: ;
		endcase
		return w;
	endfunction

	task automatic check(input string field, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s %s: expected %h, actual %h", test_name, field, exp, act);
		end
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic settle();
		#5;
	endtask

	task automatic clear_bypass();
		exu_rd = '0;
		exu_reg_wen = 1'b0;
		exu_load = 1'b0;
		exu_val = '0;
		lsu_rd = '0;
		lsu_reg_wen = 1'b0;
		lsu_load = 1'b0;
		lsu_ready = 1'b1; // memory idle
		lsu_val = '0;
	endtask

	task automatic present(input logic [31:0] w);
		exp_pc = {lfsr_bits(30), 2'b00};
		exp_dnpc = exp_pc + 32'd4;
		inst = w;
		pc = exp_pc;
		dnpc = exp_dnpc;
		idu_valid = 1'b1;
	endtask

	// inputs are only driven at +2, so idu_ready seen at +7 holds at the edge
	task automatic wait_accept();
		settle();
		while (!idu_ready) begin
			@(posedge clock);
			#7;
		end
		next_cycle();
		idu_valid = 1'b0;
	endtask

	task automatic drain();
		exu_ready = 1'b1;
		next_cycle();
		exu_ready = 1'b0;
		check("exu_valid after take", 0, exu_valid);
	endtask

	task automatic run_inst(input logic [31:0] w);
		present(w);
		wait_accept();
		check("exu_valid", 1, exu_valid);
		drain();
	endtask

	task automatic write_reg(input logic [3:0] a, input logic [31:0] d);
		wb_en = 1'b1;
		wb_rd = a;
		wb_data = d;
		next_cycle();
		wb_en = 1'b0;
		if (a != 4'd0)
			model[a] = d;
	endtask

	task automatic read_check(input logic [31:0] w);
		run_inst(w);
		check("src1", model[w[18:15]], dec_src1);
		check("src2", model[w[23:20]], dec_src2);
	endtask

	task automatic decode_class(input int c, input logic [2:0] f3);
		logic [7:0]  code;
		logic [31:0] r;
		logic [31:0] e;
		logic [31:0] w;
		logic        exp_wen;
		code = class_code(c);
		r = lfsr_bits(32);
		e = expect_imm(code[7:5], lfsr_bits(32));
		w = encode(code[7:5], code[4:0], r[3:0], r[7:4], r[11:8], f3, r[18:12], e);
		// S and B write nothing, nor does a csr word with funct3 zero
		exp_wen = !(code[7:5] inside {3'd2, 3'd3}) && !(c == 10 && f3 == 3'b000);
		run_inst(w);
		check("cls", c, dec_cls);
		check("funct3", w[14:12], dec_funct3);
		check("funct7_5", w[30], dec_funct7_5);
		check("rd", w[10:7], dec_rd);
		check("imm", e, dec_imm);
		check("reg_wen", exp_wen, dec_reg_wen);
		check("pc", exp_pc, dec_pc);
		check("dnpc", exp_dnpc, dec_dnpc);
		check("system flags", 0, {dec_ecall, dec_mret, dec_fencei});
	endtask

	task automatic system_word(input logic [31:0] w, input int c, input logic [2:0] flags,
		input logic [31:0] imm);
		run_inst(w);
		check("cls", c, dec_cls);
		check("ecall mret fencei", flags, {dec_ecall, dec_mret, dec_fencei});
		check("imm", imm, dec_imm);
		check("reg_wen", 0, dec_reg_wen);
	endtask

	task automatic stall_then_accept(input logic [31:0] w, input bit release_exu);
		present(w);
		repeat (3) begin
			settle();
			check("idu_ready while stalled", 0, idu_ready);
			next_cycle();
		end
		if (release_exu)
			exu_ready = 1'b1; // load result is back
		else
			lsu_ready = 1'b1;
		wait_accept();
		check("exu_valid", 1, exu_valid);
		drain();
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_classes();
		test_name = "classes";
		for (int c = 1; c <= 10; c++) begin
			decode_class(c, lfsr_bits(3));
		end
	endtask

	task automatic test_flags();
		test_name = "flags";
		decode_class(10, 3'b000);
		decode_class(10, 3'b010);
		system_word(32'h0000_0073, 10, 3'b100, 32'h0);   // ecall
		system_word(32'h3020_0073, 10, 3'b010, 32'h302); // mret
		system_word(32'h0000_100f, 0, 3'b001, 32'h0);    // fence.i
		system_word({lfsr_bits(25), 7'b1010111}, 0, 3'b000, 32'h0);
	endtask

	task automatic test_regs();
		logic [31:0] r;
		test_name = "regs";
		for (int i = 0; i < 24; i++) begin
			r = lfsr_bits(32);
			write_reg(r[3:0], lfsr_bits(32));
		end
		write_reg(4'd0, 32'hdead_beef);
		for (int i = 0; i < 8; i++) begin
			r = lfsr_bits(32);
			read_check(encode(3'd0, 5'b01100, r[3:0], r[7:4], r[11:8], 3'b000, 7'b0, 32'b0));
		end
		read_check(encode(3'd0, 5'b01100, 4'd1, 4'd0, 4'd0, 3'b000, 7'b0, 32'b0));
		r = lfsr_bits(32);
		read_check(encode(3'd1, 5'b00100, r[3:0], r[7:4], 4'd0, 3'b000, 7'b0, r)); // addi
		r = lfsr_bits(32);
		read_check(encode(3'd4, 5'b01101, r[3:0], 4'd0, 4'd0, 3'b000, 7'b0, r));   // lui
	endtask

	task automatic test_forward();
		logic [3:0]  rs1;
		logic [3:0]  rs2;
		logic [31:0] w;
		logic [31:0] xv;
		logic [31:0] mv;
		test_name = "forward";
		rs1 = {1'b0, 3'(lfsr_bits(3))} | 4'd1; // 1..7
		rs2 = {1'b1, 3'(lfsr_bits(3))};        // 8..15
		xv = lfsr_bits(32);
		mv = lfsr_bits(32);
		w = encode(3'd0, 5'b01100, 4'd5, rs1, rs2, 3'b000, 7'b0, 32'b0);
		exu_rd = rs1;
		exu_reg_wen = 1'b1;
		exu_val = xv;
		lsu_rd = rs2;
		lsu_reg_wen = 1'b1;
		lsu_ready = 1'b0;
		lsu_val = mv;
		run_inst(w);
		check("src1 from exu", xv, dec_src1);
		check("src2 from lsu", mv, dec_src2);
		lsu_rd = rs1; // both stages on rs1
		run_inst(w);
		check("src1 exu over lsu", xv, dec_src1);
		check("src2 from regfile", model[rs2], dec_src2);
		exu_reg_wen = 1'b0;
		run_inst(w);
		check("src1 exu without wen", mv, dec_src1);
		lsu_ready = 1'b1;
		run_inst(w);
		check("src1 lsu done", model[rs1], dec_src1);
		clear_bypass();
		exu_rd = 4'd0;
		exu_reg_wen = 1'b1;
		exu_val = xv;
		run_inst(encode(3'd0, 5'b01100, 4'd5, 4'd0, rs2, 3'b000, 7'b0, 32'b0));
		check("src1 with rd zero", 0, dec_src1);
		clear_bypass();
	endtask

	task automatic test_load_stall();
		logic [3:0]  rs1;
		logic [3:0]  rs2;
		logic [31:0] w;
		test_name = "load stall";
		rs1 = {1'b0, 3'(lfsr_bits(3))} | 4'd1;
		rs2 = {1'b1, 3'(lfsr_bits(3))};
		w = encode(3'd0, 5'b01100, 4'd3, rs1, rs2, 3'b000, 7'b0, 32'b0);
		exu_rd = rs1;
		exu_reg_wen = 1'b1;
		exu_load = 1'b1;
		exu_val = lfsr_bits(32);
		stall_then_accept(w, 1'b1);
		check("src1", model[rs1], dec_src1);
		clear_bypass();
		lsu_rd = rs2;
		lsu_reg_wen = 1'b1;
		lsu_load = 1'b1;
		lsu_ready = 1'b0;
		lsu_val = lfsr_bits(32);
		stall_then_accept(w, 1'b0);
		check("src2", model[rs2], dec_src2);
		clear_bypass();
	endtask

	task automatic test_flush();
		logic [31:0] r;
		logic [31:0] held_pc;
		logic [31:0] held_imm;
		test_name = "flush";
		r = lfsr_bits(32);
		held_imm = expect_imm(3'd1, r);
		present(encode(3'd1, 5'b00100, r[3:0], r[7:4], 4'd0, 3'b000, 7'b0, held_imm));
		wait_accept();
		held_pc = exp_pc;
		r = lfsr_bits(32);
		present(encode(3'd4, 5'b01101, 4'd2, 4'd0, 4'd0, 3'b000, 7'b0, expect_imm(3'd4, r)));
		repeat (3) begin
			settle();
			check("exu_valid held", 1, exu_valid);
			check("idu_ready held", 0, idu_ready);
			check("pc held", held_pc, dec_pc);
			check("imm held", held_imm, dec_imm);
			next_cycle();
		end
		jump_wrong = 1'b1;
		next_cycle();
		jump_wrong = 1'b0;
		check("exu_valid after flush", 0, exu_valid);
		check("idu_ready after flush", 1, idu_ready);
		wait_accept();
		check("exu_valid", 1, exu_valid);
		check("pc", exp_pc, dec_pc);
		check("cls", 1, dec_cls);
		drain();
	endtask

	initial begin
		for (int i = 0; i < 16; i++) begin
			model[i] = '0;
		end
		rst = 1'b1;
		inst = '0;
		pc = '0;
		dnpc = '0;
		idu_valid = 1'b0;
		wb_en = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		jump_wrong = 1'b0;
		exu_ready = 1'b0; // execute busy unless taking an item
		clear_bypass();
		repeat (3) @(posedge clock);
		#2;
		rst = 1'b0;
		test_name = "reset";
		check("exu_valid", 0, exu_valid);
		check("idu_ready", 1, idu_ready);
		test_classes();
		test_flags();
		test_regs();
		test_forward();
		test_load_stall();
		test_flush();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- rv_front.f
+incdir+.
rv_decode_pkg.sv
rv_pipe_pkg.sv
rv_bypass_if.sv
rv_regfile.sv
rv_imm_gen.sv
rv_hazard.sv
rv_idu.sv
rv_front_top.sv
tb_rv_front.sv

//--- Bender.yml
package:
  name: rv_front

sources:
  - include_dirs:
      - .
    files:
      - rv_decode_pkg.sv
      - rv_pipe_pkg.sv
      - rv_bypass_if.sv
      - rv_regfile.sv
      - rv_imm_gen.sv
      - rv_hazard.sv
      - rv_idu.sv
      - rv_front_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_front.sv
